// ==== Makefile ====
TOP = tb_decode_pipe

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f rv32i_decode_pipe.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== control_rom.sv ====
`timescale 1ns/1ps

module control_rom
(
	input rv32i_types::rv32i_opcode opcode,
	input logic [2:0] funct3,
	input logic [6:0] funct7,
	output rv32i_types::alu_op alu,
	output rv32i_types::opa_sel opa,
	output rv32i_types::opb_sel opb,
	output logic wb_en,
	output logic illegal
);

localparam logic [6:0] f7_base = 7'b0000000; // add, srl and friends
localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra

// funct3 to operation for the base funct7 encoding
function automatic rv32i_types::alu_op base_alu(input logic [2:0] f3);
	case (f3)
		3'b000:  base_alu = rv32i_types::alu_add;
		3'b001:  base_alu = rv32i_types::alu_sll;
		3'b010:  base_alu = rv32i_types::alu_slt;
		3'b011:  base_alu = rv32i_types::alu_sltu;
		3'b100:  base_alu = rv32i_types::alu_xor;
		3'b101:  base_alu = rv32i_types::alu_srl;
		3'b110:  base_alu = rv32i_types::alu_or;
		default: base_alu = rv32i_types::alu_and;
	endcase
endfunction

always_comb begin
	alu = rv32i_types::alu_add;     // defaults cover lui and auipc
	opa = rv32i_types::opa_rs1;
	opb = rv32i_types::opb_rs2;
	wb_en = 1'b0;
	illegal = 1'b0;
	case (opcode)
		rv32i_types::op_lui: begin
			opb = rv32i_types::opb_imm; // x0 + u-imm
			wb_en = 1'b1;
		end
		rv32i_types::op_auipc: begin
			opa = rv32i_types::opa_pc;  // pc + u-imm
			opb = rv32i_types::opb_imm;
			wb_en = 1'b1;
		end
		rv32i_types::op_imm: begin
			opb = rv32i_types::opb_imm;
			wb_en = 1'b1;
			alu = base_alu(funct3);
			if (funct3 == 3'b001 && funct7 != f7_base) begin
				illegal = 1'b1;         // slli needs zero upper bits
			end else if (funct3 == 3'b101) begin
				if (funct7 == f7_alt) begin
					alu = rv32i_types::alu_sra; // srai
				end else if (funct7 != f7_base) begin
					illegal = 1'b1;
				end
			end
		end
		rv32i_types::op_reg: begin
			wb_en = 1'b1;
			if (funct7 == f7_base) begin
				alu = base_alu(funct3);
			end else if (funct7 == f7_alt && funct3 == 3'b000) begin
				alu = rv32i_types::alu_sub;
			end else if (funct7 == f7_alt && funct3 == 3'b101) begin
				alu = rv32i_types::alu_sra;
			end else begin
				illegal = 1'b1;             // unknown funct7 / funct3 pair
			end
		end
		default: illegal = 1'b1;        // loads, stores, branches etc.
	endcase
	if (illegal) begin
		wb_en = 1'b0;                   // illegal never writes
	end
end

endmodule : control_rom

// ==== decode.sv ====
`timescale 1ns/1ps

module decode
#(
	parameter int FIFO_DEPTH = 4
)
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	output logic instr_ready,
	input rv32i_types::rv32i_word instr,
	input rv32i_types::rv32i_word instr_pc,
	output logic dec_valid,
	input logic dec_ready,
	output rv32i_types::rv32i_word dec_pc,
	output rv32i_types::reg_idx dec_rd,
	output rv32i_types::rv32i_word dec_rs1_val,
	output rv32i_types::rv32i_word dec_rs2_val,
	output rv32i_types::rv32i_word dec_imm,
	output rv32i_types::alu_op dec_alu,
	output rv32i_types::opa_sel dec_opa,
	output rv32i_types::opb_sel dec_opb,
	output logic dec_wb_en,
	output logic dec_illegal,
	input logic wb_we,
	input rv32i_types::reg_idx wb_rd,
	input rv32i_types::rv32i_word wb_data
);

localparam int cnt_w = $clog2(FIFO_DEPTH + 3); // in flight: out reg + fifo + execute

rv32i_types::rv32i_opcode opcode;
rv32i_types::reg_idx rs1, rs2, rd;
logic [2:0] funct3;
logic [6:0] funct7;
rv32i_types::rv32i_word imm_i, imm_u, imm;
rv32i_types::rv32i_word rdata_a, rdata_b, rs1_val, rs2_val;
rv32i_types::alu_op alu;
rv32i_types::opa_sel opa;
rv32i_types::opb_sel opb;
logic wb_en, illegal;
logic [cnt_w-1:0] pend [32];                   // pending writes per register
logic rs1_used, rs2_used, stall_a, stall_b;
logic slot_free, accept, inc, run;

assign opcode = instr[6:0];
assign rd = instr[11:7];
assign funct3 = instr[14:12];
assign rs1 = (opcode == rv32i_types::op_lui) ? '0 : instr[19:15]; // lui adds to x0
assign rs2 = instr[24:20];
assign funct7 = instr[31:25];
assign imm_i = {{20{instr[31]}}, instr[31:20]};  // shamt in low 5 bits
assign imm_u = {instr[31:12], 12'h000};
assign imm = (opcode == rv32i_types::op_lui || opcode == rv32i_types::op_auipc) ? imm_u : imm_i;

control_rom u_rom
(
	.opcode(opcode),
	.funct3(funct3),
	.funct7(funct7),
	.alu(alu),
	.opa(opa),
	.opb(opb),
	.wb_en(wb_en),
	.illegal(illegal)
);

regfile u_rf
(
	.clk(clk),
	.rst_n(rst_n),
	.we(wb_we),                                  // from execute writeback
	.waddr(wb_rd),
	.wdata(wb_data),
	.raddr_a(rs1),
	.raddr_b(rs2),
	.rdata_a(rdata_a),
	.rdata_b(rdata_b)
);

assign rs1_val = (wb_we && wb_rd == rs1) ? wb_data : rdata_a; // same-cycle bypass
assign rs2_val = (wb_we && wb_rd == rs2) ? wb_data : rdata_b;

assign rs1_used = !illegal && opa == rv32i_types::opa_rs1;
assign rs2_used = !illegal && opb == rv32i_types::opb_rs2;
// a retiring last write to the source is fine, bypass covers it
assign stall_a = rs1_used && pend[rs1] != '0 &&
	!(wb_we && wb_rd == rs1 && pend[rs1] == cnt_w'(1));
assign stall_b = rs2_used && pend[rs2] != '0 &&
	!(wb_we && wb_rd == rs2 && pend[rs2] == cnt_w'(1));

assign slot_free = !dec_valid || dec_ready;    // out reg empty or draining
assign instr_ready = run && slot_free && !stall_a && !stall_b;
assign accept = instr_valid && instr_ready;
assign inc = accept && wb_en && rd != '0;      // x0 never retires a write

always_ff @(posedge clk) begin
	if (!rst_n) begin
		run <= 1'b0;                             // holds ready low out of reset
		dec_valid <= 1'b0;
		for (int r = 0; r < 32; r++) begin
			pend[r] <= '0;
		end
	end else begin
		run <= 1'b1;
		if (slot_free) begin
			dec_valid <= accept;
		end
		for (int r = 0; r < 32; r++) begin
			pend[r] <= pend[r] + cnt_w'(inc && rd == rv32i_types::reg_idx'(r))
				- cnt_w'(wb_we && wb_rd == rv32i_types::reg_idx'(r));
		end
	end
end

always_ff @(posedge clk) begin
	if (accept) begin                          // payload, valid qualifies it
		dec_pc <= instr_pc;
		dec_rd <= rd;
		dec_rs1_val <= rs1_val;
		dec_rs2_val <= rs2_val;
		dec_imm <= imm;
		dec_alu <= alu;
		dec_opa <= opa;
		dec_opb <= opb;
		dec_wb_en <= wb_en;
		dec_illegal <= illegal;
	end
end

endmodule : decode

// ==== decode_pipe_top.sv ====
`timescale 1ns/1ps

module decode_pipe_top
#(
	parameter int FIFO_DEPTH = 4
)
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	output logic instr_ready,
	input rv32i_types::rv32i_word instr,
	input rv32i_types::rv32i_word instr_pc,
	output logic wb_valid,
	output logic wb_we,
	output rv32i_types::reg_idx wb_rd,
	output rv32i_types::rv32i_word wb_data,
	output rv32i_types::rv32i_word wb_pc,
	output logic wb_illegal
);

logic dec_valid, dec_ready, ex_valid, ex_ready;
rv32i_types::rv32i_word dec_pc, dec_rs1_val, dec_rs2_val, dec_imm;
rv32i_types::rv32i_word ex_pc, ex_rs1_val, ex_rs2_val, ex_imm;
rv32i_types::reg_idx dec_rd, ex_rd;
rv32i_types::alu_op dec_alu, ex_alu;
rv32i_types::opa_sel dec_opa, ex_opa;
rv32i_types::opb_sel dec_opb, ex_opb;
logic dec_wb_en, dec_illegal, ex_wb_en, ex_illegal;

decode #(.FIFO_DEPTH(FIFO_DEPTH)) u_decode
(
	.clk(clk), .rst_n(rst_n),
	.instr_valid(instr_valid), .instr_ready(instr_ready),
	.instr(instr), .instr_pc(instr_pc),
	.dec_valid(dec_valid), .dec_ready(dec_ready),
	.dec_pc(dec_pc), .dec_rd(dec_rd), .dec_rs1_val(dec_rs1_val), .dec_rs2_val(dec_rs2_val),
	.dec_imm(dec_imm), .dec_alu(dec_alu), .dec_opa(dec_opa), .dec_opb(dec_opb),
	.dec_wb_en(dec_wb_en), .dec_illegal(dec_illegal),
	.wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)   // writeback into the regfile
);

stage_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
(
	.clk(clk), .rst_n(rst_n),
	.in_valid(dec_valid), .in_ready(dec_ready),
	.dec_pc(dec_pc), .dec_rd(dec_rd), .dec_rs1_val(dec_rs1_val), .dec_rs2_val(dec_rs2_val),
	.dec_imm(dec_imm), .dec_alu(dec_alu), .dec_opa(dec_opa), .dec_opb(dec_opb),
	.dec_wb_en(dec_wb_en), .dec_illegal(dec_illegal),
	.out_valid(ex_valid), .out_ready(ex_ready),
	.ex_pc(ex_pc), .ex_rd(ex_rd), .ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val),
	.ex_imm(ex_imm), .ex_alu(ex_alu), .ex_opa(ex_opa), .ex_opb(ex_opb),
	.ex_wb_en(ex_wb_en), .ex_illegal(ex_illegal)
);

execute u_execute
(
	.clk(clk), .rst_n(rst_n),
	.in_valid(ex_valid), .in_ready(ex_ready),
	.ex_pc(ex_pc), .ex_rd(ex_rd), .ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val),
	.ex_imm(ex_imm), .ex_alu(ex_alu), .ex_opa(ex_opa), .ex_opb(ex_opb),
	.ex_wb_en(ex_wb_en), .ex_illegal(ex_illegal),
	.wb_valid(wb_valid), .wb_we(wb_we), .wb_rd(wb_rd),
	.wb_data(wb_data), .wb_pc(wb_pc), .wb_illegal(wb_illegal)  // also top outputs
);

endmodule : decode_pipe_top

// ==== execute.sv ====
`timescale 1ns/1ps

module execute
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input rv32i_types::rv32i_word ex_pc,
	input rv32i_types::reg_idx ex_rd,
	input rv32i_types::rv32i_word ex_rs1_val,
	input rv32i_types::rv32i_word ex_rs2_val,
	input rv32i_types::rv32i_word ex_imm,
	input rv32i_types::alu_op ex_alu,
	input rv32i_types::opa_sel ex_opa,
	input rv32i_types::opb_sel ex_opb,
	input logic ex_wb_en,
	input logic ex_illegal,
	output logic wb_valid,
	output logic wb_we,
	output rv32i_types::reg_idx wb_rd,
	output rv32i_types::rv32i_word wb_data,
	output rv32i_types::rv32i_word wb_pc,
	output logic wb_illegal
);

typedef enum logic {st_idle, st_shift} ex_state_t;

ex_state_t state;
rv32i_types::rv32i_word op_a, op_b, sh_val;
rv32i_types::alu_op sh_op;
logic [4:0] shamt, sh_cnt;                    // remaining bit shifts
logic is_shift, accept, sh_wb_en, we_now;

// single cycle ops, a shift only gets here with a zero amount
function automatic rv32i_types::rv32i_word alu_result(input rv32i_types::alu_op op,
	input rv32i_types::rv32i_word a, input rv32i_types::rv32i_word b);
	case (op)
		rv32i_types::alu_add:  alu_result = a + b;
		rv32i_types::alu_sub:  alu_result = a - b;
		rv32i_types::alu_slt:  alu_result = {31'b0, $signed(a) < $signed(b)};
		rv32i_types::alu_sltu: alu_result = {31'b0, a < b};
		rv32i_types::alu_xor:  alu_result = a ^ b;
		rv32i_types::alu_or:   alu_result = a | b;
		rv32i_types::alu_and:  alu_result = a & b;
		default:               alu_result = a;  // shift by 0
	endcase
endfunction

function automatic rv32i_types::rv32i_word shift_one(input rv32i_types::alu_op op,
	input rv32i_types::rv32i_word v);
	case (op)
		rv32i_types::alu_sll: shift_one = {v[30:0], 1'b0};
		rv32i_types::alu_sra: shift_one = {v[31], v[31:1]}; // sign fill
		default:              shift_one = {1'b0, v[31:1]};
	endcase
endfunction

assign op_a = (ex_opa == rv32i_types::opa_pc) ? ex_pc : ex_rs1_val;
assign op_b = (ex_opb == rv32i_types::opb_imm) ? ex_imm : ex_rs2_val;
assign shamt = op_b[4:0];
assign is_shift = !ex_illegal && shamt != '0 && (ex_alu == rv32i_types::alu_sll ||
	ex_alu == rv32i_types::alu_srl || ex_alu == rv32i_types::alu_sra);
assign in_ready = state == st_idle;           // blocked while shifting
assign accept = in_valid && in_ready;
assign we_now = ex_wb_en && !ex_illegal && ex_rd != '0;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= st_idle;
		wb_valid <= 1'b0;
		wb_we <= 1'b0;
	end else begin
		wb_valid <= 1'b0;                       // pulses only
		wb_we <= 1'b0;
		if (state == st_idle && accept && is_shift) begin
			state <= st_shift;
		end else if (state == st_idle && accept) begin
			wb_valid <= 1'b1;                     // alu result next cycle
			wb_we <= we_now;
		end else if (state == st_shift && sh_cnt == 5'd1) begin
			state <= st_idle;                     // last bit this edge
			wb_valid <= 1'b1;
			wb_we <= sh_wb_en;
		end
	end
end

always_ff @(posedge clk) begin
	if (accept) begin
		sh_val <= op_a;
		sh_cnt <= shamt;
		sh_op <= ex_alu;
		sh_wb_en <= we_now;
		wb_rd <= ex_rd;                         // held through the shift
		wb_pc <= ex_pc;
		wb_illegal <= ex_illegal;
		wb_data <= ex_illegal ? '0 : alu_result(ex_alu, op_a, op_b);
	end else if (state == st_shift) begin
		sh_val <= shift_one(sh_op, sh_val);
		sh_cnt <= sh_cnt - 5'd1;
		wb_data <= shift_one(sh_op, sh_val);    // final value lands with the pulse
	end
end

endmodule : execute

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile
(
	input logic clk,
	input logic rst_n,
	input logic we,
	input rv32i_types::reg_idx waddr,
	input rv32i_types::rv32i_word wdata,
	input rv32i_types::reg_idx raddr_a,
	input rv32i_types::reg_idx raddr_b,
	output rv32i_types::rv32i_word rdata_a,
	output rv32i_types::rv32i_word rdata_b
);

rv32i_types::rv32i_word regs [32];

always_ff @(posedge clk) begin
	if (!rst_n) begin
		for (int r = 0; r < 32; r++) begin
			regs[r] <= '0;                // whole file cleared
		end
	end else if (we && waddr != '0) begin
		regs[waddr] <= wdata;             // x0 stays zero
	end
end

// old value during a write, decode bypasses the new one
assign rdata_a = regs[raddr_a];
assign rdata_b = regs[raddr_b];

endmodule : regfile

// ==== rv32i_decode_pipe.f ====
rv32i_types.sv
control_rom.sv
regfile.sv
decode.sv
stage_fifo.sv
execute.sv
decode_pipe_top.sv
tb_decode_pipe.sv

// ==== rv32i_types.sv ====
package rv32i_types;

typedef logic [31:0] rv32i_word;    // data word or pc
typedef logic [4:0]  reg_idx;       // architectural register number
typedef logic [6:0]  rv32i_opcode;  // instr[6:0]
typedef logic [3:0]  alu_op;        // execute operation select
typedef logic        opa_sel;       // operand a source
typedef logic        opb_sel;       // operand b source

// major opcodes handled by this pipe
localparam rv32i_opcode op_lui   = 7'b0110111; // rd = u-imm
localparam rv32i_opcode op_auipc = 7'b0010111; // rd = pc + u-imm
localparam rv32i_opcode op_imm   = 7'b0010011; // reg-imm arithmetic
localparam rv32i_opcode op_reg   = 7'b0110011; // reg-reg arithmetic

// alu encoding is {funct7[5], funct3} of the matching OP instruction
localparam alu_op alu_add  = 4'b0000;
localparam alu_op alu_sll  = 4'b0001;
localparam alu_op alu_slt  = 4'b0010;
localparam alu_op alu_sltu = 4'b0011;
localparam alu_op alu_xor  = 4'b0100;
localparam alu_op alu_srl  = 4'b0101;
localparam alu_op alu_or   = 4'b0110;
localparam alu_op alu_and  = 4'b0111;
localparam alu_op alu_sub  = 4'b1000; // funct7 alternate of add
localparam alu_op alu_sra  = 4'b1101; // funct7 alternate of srl

localparam opa_sel opa_rs1 = 1'b0; // register value, x0 for lui
localparam opa_sel opa_pc  = 1'b1; // auipc only

localparam opb_sel opb_rs2 = 1'b0; // OP
localparam opb_sel opb_imm = 1'b1; // OP-IMM, lui, auipc

endpackage : rv32i_types

// ==== stage_fifo.sv ====
`timescale 1ns/1ps

module stage_fifo
#(
	parameter int FIFO_DEPTH = 4
)
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input rv32i_types::rv32i_word dec_pc,
	input rv32i_types::reg_idx dec_rd,
	input rv32i_types::rv32i_word dec_rs1_val,
	input rv32i_types::rv32i_word dec_rs2_val,
	input rv32i_types::rv32i_word dec_imm,
	input rv32i_types::alu_op dec_alu,
	input rv32i_types::opa_sel dec_opa,
	input rv32i_types::opb_sel dec_opb,
	input logic dec_wb_en,
	input logic dec_illegal,
	output logic out_valid,
	input logic out_ready,
	output rv32i_types::rv32i_word ex_pc,
	output rv32i_types::reg_idx ex_rd,
	output rv32i_types::rv32i_word ex_rs1_val,
	output rv32i_types::rv32i_word ex_rs2_val,
	output rv32i_types::rv32i_word ex_imm,
	output rv32i_types::alu_op ex_alu,
	output rv32i_types::opa_sel ex_opa,
	output rv32i_types::opb_sel ex_opb,
	output logic ex_wb_en,
	output logic ex_illegal
);

localparam int rec_w = 4 * $bits(rv32i_types::rv32i_word) + $bits(rv32i_types::reg_idx)
	+ $bits(rv32i_types::alu_op) + 4;         // + opa, opb, wb_en, illegal
localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

logic [rec_w-1:0] mem [FIFO_DEPTH];
logic [ptr_w-1:0] wr_ptr, rd_ptr;
logic [cnt_w-1:0] count;                     // occupancy
logic push, pop;

assign out_valid = count != '0;
assign in_ready = count != cnt_w'(FIFO_DEPTH) || out_ready; // full but draining is ok
assign push = in_valid && in_ready;
assign pop = out_valid && out_ready;

assign {ex_pc, ex_rd, ex_rs1_val, ex_rs2_val, ex_imm,
	ex_alu, ex_opa, ex_opb, ex_wb_en, ex_illegal} = mem[rd_ptr]; // head of queue

always_ff @(posedge clk) begin
	if (!rst_n) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (push) begin
			wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
		end
		if (pop) begin
			rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
		count <= count + cnt_w'(push) - cnt_w'(pop);
	end
end

always_ff @(posedge clk) begin
	if (push) begin
		mem[wr_ptr] <= {dec_pc, dec_rd, dec_rs1_val, dec_rs2_val, dec_imm,
			dec_alu, dec_opa, dec_opb, dec_wb_en, dec_illegal};
	end
end

endmodule : stage_fifo

// ==== tb_decode_pipe.sv ====
`timescale 1ns/1ps

module tb_decode_pipe;

localparam int n_instr = 400;                        // length of the random stream
localparam int timeout_cycles = n_instr * 40 + 500;  // worst shift plus stalls, some margin
localparam logic [6:0] f7_alt = 7'b0100000;          // sub and sra

logic clk;
logic rst_n;
logic instr_valid;
logic instr_ready;
rv32i_types::rv32i_word instr;
rv32i_types::rv32i_word instr_pc;
logic wb_valid;
logic wb_we;
rv32i_types::reg_idx wb_rd;
rv32i_types::rv32i_word wb_data;
rv32i_types::rv32i_word wb_pc;
logic wb_illegal;

integer seed;
int retired;                                         // wb_valid pulses seen
rv32i_types::rv32i_word model_regs [32];             // architectural state
rv32i_types::rv32i_word exp_pc [$];                  // expected retirements, accept order
rv32i_types::rv32i_word exp_data [$];
rv32i_types::reg_idx exp_rd [$];
logic exp_we [$];
logic exp_illegal [$];

decode_pipe_top #(.FIFO_DEPTH(4)) u_dut
(
	.clk(clk), .rst_n(rst_n),
	.instr_valid(instr_valid), .instr_ready(instr_ready),
	.instr(instr), .instr_pc(instr_pc),
	.wb_valid(wb_valid), .wb_we(wb_we), .wb_rd(wb_rd),
	.wb_data(wb_data), .wb_pc(wb_pc), .wb_illegal(wb_illegal)
);

initial clk = 1'b0;
always #4 clk = ~clk;                                // 8 ns period

task automatic fail_and_stop(input string msg);
	$display("%s", msg);
	$display(">>> FAIL");
	$fatal(1);
endtask

task automatic check_value(input string name, input rv32i_types::rv32i_word got,
	input rv32i_types::rv32i_word exp);
	if (got !== exp) begin
		fail_and_stop($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
	end
endtask

// zero and 31 show up often, the rest uniform
function automatic logic [4:0] random_shamt();
	int unsigned r;
	r = $unsigned($random(seed)) % 8;
	if (r == 0) begin
		return 5'd0;
	end else if (r == 1) begin
		return 5'd31;
	end
	return 5'($unsigned($random(seed)));
endfunction

function automatic rv32i_types::rv32i_word random_instr();
	int unsigned pick;
	logic alt;
	rv32i_types::reg_idx rd;
	rv32i_types::reg_idx rs1;
	rv32i_types::reg_idx rs2;
	logic [2:0] f3;
	logic [6:0] f7;
	pick = $unsigned($random(seed)) % 100;
	rd = 5'($unsigned($random(seed)) % 8);           // x0..x7, lots of hazards
	rs1 = 5'($unsigned($random(seed)) % 8);
	rs2 = 5'($unsigned($random(seed)) % 8);
	f3 = 3'($unsigned($random(seed)));
	alt = ($unsigned($random(seed)) % 2) == 1;
	if (pick < 2) begin                              // load or branch opcode
		return {12'($unsigned($random(seed))), rs1, f3, rd,
			(pick == 0) ? 7'b0000011 : 7'b1100011};
	end else if (pick == 2) begin                    // M extension funct7
		return {7'b0000001, rs2, rs1, f3, rd, rv32i_types::op_reg};
	end else if (pick == 3) begin                    // slli with sra funct7
		return {f7_alt, random_shamt(), rs1, 3'b001, rd, rv32i_types::op_imm};
	end else if (pick == 4) begin                    // srli with junk funct7
		return {7'b0000010, random_shamt(), rs1, 3'b101, rd, rv32i_types::op_imm};
	end else if (pick < 13) begin
		return {20'($unsigned($random(seed))), rd, rv32i_types::op_lui};
	end else if (pick < 21) begin
		return {20'($unsigned($random(seed))), rd, rv32i_types::op_auipc};
	end else if (pick < 60) begin
		if (f3 == 3'b001) begin
			return {7'b0000000, random_shamt(), rs1, f3, rd, rv32i_types::op_imm};
		end else if (f3 == 3'b101) begin
			f7 = alt ? f7_alt : 7'b0000000;
			return {f7, random_shamt(), rs1, f3, rd, rv32i_types::op_imm};
		end
		return {12'($unsigned($random(seed))), rs1, f3, rd, rv32i_types::op_imm};
	end
	f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? f7_alt : 7'b0000000;
	return {f7, rs2, rs1, f3, rd, rv32i_types::op_reg};
endfunction

// reference semantics, applied in accept order
task automatic record_expected(input rv32i_types::rv32i_word w, input rv32i_types::rv32i_word pc);
	rv32i_types::rv32i_word a;
	rv32i_types::rv32i_word b;
	rv32i_types::rv32i_word res;
	logic bad;
	logic [4:0] sh;
	logic [2:0] f3;
	logic [6:0] f7;
	a = model_regs[w[19:15]];
	b = (w[6:0] == rv32i_types::op_reg) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
	sh = b[4:0];                                     // shamt from rs2 or imm
	f3 = w[14:12];
	f7 = w[31:25];
	res = '0;
	bad = 1'b0;
	case (w[6:0])
		rv32i_types::op_lui:   res = {w[31:12], 12'h000};
		rv32i_types::op_auipc: res = pc + {w[31:12], 12'h000};
		rv32i_types::op_imm, rv32i_types::op_reg: begin
			case (f3)
				3'b000:  res = (w[6:0] == rv32i_types::op_reg && f7 == f7_alt) ? a - b : a + b;
				3'b001:  res = a << sh;
				3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'b011:  res = (a < b) ? 32'd1 : 32'd0;
				3'b100:  res = a ^ b;
				3'b101:  res = (f7 == f7_alt) ? $unsigned($signed(a) >>> sh) : a >> sh;
				3'b110:  res = a | b;
				default: res = a & b;
			endcase
			if (w[6:0] == rv32i_types::op_reg || f3 == 3'b001 || f3 == 3'b101) begin
				bad = !(f7 == 7'b0000000 || (f7 == f7_alt && (f3 == 3'b101 ||
					(f3 == 3'b000 && w[6:0] == rv32i_types::op_reg)))); // funct7 is checked here
			end
		end
		default: bad = 1'b1;                         // outside the supported set
	endcase
	exp_pc.push_back(pc);
	exp_rd.push_back(w[11:7]);
	exp_we.push_back(!bad && w[11:7] != 5'd0);
	exp_illegal.push_back(bad);
	exp_data.push_back(res);
	if (!bad && w[11:7] != 5'd0) begin
		model_regs[w[11:7]] = res;                   // x0 never changes
	end
endtask

task automatic check_retirement();
	if (exp_pc.size() == 0) begin
		fail_and_stop("unexpected retirement: wb_valid with no instruction outstanding");
	end else begin
		check_value("wb_pc", wb_pc, exp_pc[0]);
		check_value("wb_rd", 32'(wb_rd), 32'(exp_rd[0]));
		check_value("wb_we", 32'(wb_we), 32'(exp_we[0]));
		check_value("wb_illegal", 32'(wb_illegal), 32'(exp_illegal[0]));
		if (!exp_illegal[0]) begin
			check_value("wb_data", wb_data, exp_data[0]); // no result defined when illegal
		end
		void'(exp_pc.pop_front());
		void'(exp_rd.pop_front());
		void'(exp_we.pop_front());
		void'(exp_illegal.pop_front());
		void'(exp_data.pop_front());
		retired++;
	end
endtask

// holds the word until decode takes it, ready is sampled mid cycle
task automatic send_instr(input rv32i_types::rv32i_word w, input rv32i_types::rv32i_word pc);
	instr = w;
	instr_pc = pc;
	instr_valid = 1'b1;
	@(negedge clk);
	while (!instr_ready) begin
		@(negedge clk);
	end
	record_expected(w, pc);                          // taken on the coming edge
	@(posedge clk);
	#1;
endtask

always @(negedge clk) begin
	if (rst_n && wb_valid) begin
		check_retirement();                          // wb outputs are registered, stable here
	end
end

initial begin
	#(timeout_cycles * 8);
	fail_and_stop($sformatf("timeout: retirement stalled, %0d of %0d instructions retired",
		retired, n_instr));
end

initial begin
	rv32i_types::rv32i_word pc;
	seed = 32'h6bba;
	rst_n = 1'b0;
	instr_valid = 1'b0;
	instr = '0;
	instr_pc = '0;
	retired = 0;
	pc = 32'h0000_1000;
	for (int r = 0; r < 32; r++) begin
		model_regs[r] = '0;
	end
	repeat (4) @(posedge clk);
	@(negedge clk);
	check_value("instr_ready", 32'(instr_ready), 32'd0); // no accept during reset
	check_value("wb_valid", 32'(wb_valid), 32'd0);
	@(posedge clk);                                  // fifth reset edge
	#1;
	rst_n = 1'b1;
	for (int n = 0; n < n_instr; n++) begin
		if (n < 8) begin
			// slli by 31 from x0, never stalls, so the fifo fills up
			send_instr({7'b0000000, 5'd31, 5'd0, 3'b001, 5'(n), rv32i_types::op_imm}, pc);
		end else begin
			send_instr(random_instr(), pc);
		end
		pc = pc + 32'd4;
		if ($unsigned($random(seed)) % 4 == 0) begin
			instr_valid = 1'b0;                      // idle gap of 1 to 3 cycles
			repeat (1 + $unsigned($random(seed)) % 3) @(posedge clk);
			#1;
		end
	end
	instr_valid = 1'b0;
	wait (retired == n_instr);
	repeat (20) @(posedge clk);                      // room for stray pulses
	$display(">>> PASS");
	$finish;
end

endmodule : tb_decode_pipe
